// ==== Bender.yml ====
package:
  name: tensor_addr_gen

sources:
  - files:
      - source/im2col_pkg.sv
      - source/conv_geometry.sv
      - source/tile_counter.sv
      - source/kernel_walker.sv
      - source/window_base.sv
      - source/addr_issue.sv
      - source/tensor_addr_gen.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/tensor_addr_gen_tb.sv

// ==== source/addr_issue.sv ====
`timescale 1ns/1ps

module addr_issue (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          enable,
    input  im2col_pkg::tile_evt_t         evt,
    input  logic                          elem_pad,
    input  logic                          window_pad,
    input  logic                          final_group,
    input  logic [im2col_pkg::ADDR_W-1:0] kernel_offset,
    input  logic [im2col_pkg::ADDR_W-1:0] window_base_addr,
    output logic [im2col_pkg::ADDR_W-1:0] o_tensor_addr,
    output logic                          padding_valid,
    output logic                          o_addr_valid,
    output logic                          o_tensor_done
);
    import im2col_pkg::*;

    issue_t issue_d;
    issue_t issue_q;

    always_comb begin
        issue_d.pad  = elem_pad || window_pad;
        // padding slots read address 0
        issue_d.addr = issue_d.pad ? '0 : window_base_addr + kernel_offset;
        issue_d.done = evt.group_last && final_group;
    end

    // ************************************************************************
    // output stage, held while enable is low
    // ************************************************************************

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            issue_q      <= '0;
            o_addr_valid <= 1'b0;
        end else begin
            o_addr_valid <= enable;
            if (enable) begin
                issue_q <= issue_d;
            end
        end
    end

    assign o_tensor_addr = issue_q.addr;
    assign padding_valid = issue_q.pad;
    assign o_tensor_done = issue_q.done;

endmodule

// ==== source/conv_geometry.sv ====
`timescale 1ns/1ps

module conv_geometry (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  cfg_load,
    input  im2col_pkg::conv_cfg_t cfg,
    output im2col_pkg::geom_t     geom
);
    import im2col_pkg::*;

    geom_t                geom_d;
    logic [STRIDE_W-1:0]  stride_nz;
    logic [TENSOR_W-1:0]  span;
    logic [TENSOR_W:0]    out_cnt;
    logic [2*TENSOR_W:0]  win_cnt;
    logic [ADDR_W-1:0]    tensor_sq;
    logic [ADDR_W-1:0]    back_step;
    logic [ADDR_W-1:0]    elem_m1;

    // ************************************************************************
    // derived geometry, one multiply and divide stage
    // ************************************************************************

    always_comb begin
        // zero stride behaves as 1
        stride_nz = (cfg.stride == '0) ? STRIDE_W'(1) : cfg.stride;
        span      = cfg.tensor_size - TENSOR_W'(cfg.kernel_size);
        geom_d.out_last = span / TENSOR_W'(stride_nz);
        out_cnt   = {1'b0, geom_d.out_last} + 1'b1;
        win_cnt   = (2*TENSOR_W+1)'(out_cnt) * (2*TENSOR_W+1)'(out_cnt);
        tensor_sq = ADDR_W'(cfg.tensor_size) * ADDR_W'(cfg.tensor_size);
        back_step = ADDR_W'(cfg.kernel_size - 1'b1) * (ADDR_W'(cfg.tensor_size) + 1'b1);
        // kernel elements minus one, k*k*c - 1
        elem_m1   = ADDR_W'(cfg.kernel_size) * ADDR_W'(cfg.kernel_size)
                    * ADDR_W'(cfg.channels) - 1'b1;

        geom_d.row_step        = ADDR_W'(cfg.tensor_size) * ADDR_W'(stride_nz);
        geom_d.kernel_row_step = span + 1'b1;
        geom_d.channel_step    = tensor_sq - back_step;
        geom_d.win_last        = ADDR_W'(win_cnt - 1'b1);
        geom_d.block_last      = BLOCK_W'(elem_m1 / ADDR_W'(TILE_SIZE));
        geom_d.tail_last       = TILE_W'(elem_m1 % ADDR_W'(TILE_SIZE));
        geom_d.kernel_last     = cfg.kernel_size - 1'b1;
        geom_d.stride          = stride_nz;
    end

    // configuration register, loaded straight from cfg
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            geom <= '0;
        end else if (cfg_load) begin
            geom <= geom_d;
        end
    end

endmodule

// ==== source/im2col_pkg.sv ====
package im2col_pkg;

    // ************************************************************************
    // sizes
    // ************************************************************************

    // square tile edge of the im2col matrix
    localparam int TILE_SIZE = 4;
    localparam int TILE_W    = 2;
    localparam int TENSOR_W  = 8;
    localparam int KERNEL_W  = 3;
    localparam int CHANNEL_W = 4;
    localparam int STRIDE_W  = 2;
    localparam int ADDR_W    = 16;
    localparam int BLOCK_W   = 6;

    // last index of a tile row or column
    localparam logic [TILE_W-1:0] TILE_LAST = TILE_W'(TILE_SIZE - 1);

    // ************************************************************************
    // shared structs
    // ************************************************************************

    typedef struct packed {
        logic [TENSOR_W-1:0]  tensor_size;
        logic [KERNEL_W-1:0]  kernel_size;
        logic [CHANNEL_W-1:0] channels;
        logic [STRIDE_W-1:0]  stride;
    } conv_cfg_t;

    // derived constants, held for a whole walk
    typedef struct packed {
        logic [TENSOR_W-1:0] out_last;
        logic [ADDR_W-1:0]   row_step;
        logic [TENSOR_W-1:0] kernel_row_step;
        logic [ADDR_W-1:0]   channel_step;
        // index of the last real window
        logic [ADDR_W-1:0]   win_last;
        logic [BLOCK_W-1:0]  block_last;
        logic [TILE_W-1:0]   tail_last;
        logic [KERNEL_W-1:0] kernel_last;
        logic [STRIDE_W-1:0] stride;
    } geom_t;

    // qualifiers of the item in the current cycle
    typedef struct packed {
        logic elem_last;
        logic tile_last;
        // first item of any block
        logic block_first;
        // first item of block 0
        logic group_first;
        logic group_last;
    } tile_evt_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              pad;
        logic              done;
    } issue_t;

endpackage

// ==== source/kernel_walker.sv ====
`timescale 1ns/1ps

module kernel_walker (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          enable,
    input  im2col_pkg::geom_t             geom,
    input  im2col_pkg::tile_evt_t         evt,
    output logic [im2col_pkg::ADDR_W-1:0] kernel_offset
);
    import im2col_pkg::*;

    logic [ADDR_W-1:0]   offset;
    logic [KERNEL_W-1:0] kcol;
    logic [KERNEL_W-1:0] krow;

    // block start, replayed for every window of the block
    logic [ADDR_W-1:0]   offset_save;
    logic [KERNEL_W-1:0] kcol_save;
    logic [KERNEL_W-1:0] krow_save;

    logic [ADDR_W-1:0]   offset_step;
    logic [KERNEL_W-1:0] kcol_next;
    logic [KERNEL_W-1:0] krow_next;

    // ************************************************************************
    // next kernel element
    // ************************************************************************

    always_comb begin
        kcol_next   = kcol + 1'b1;
        krow_next   = krow;
        offset_step = ADDR_W'(1);
        if (kcol == geom.kernel_last) begin
            kcol_next = '0;
            if (krow == geom.kernel_last) begin
                // next channel plane
                krow_next   = '0;
                offset_step = geom.channel_step;
            end else begin
                krow_next   = krow + 1'b1;
                offset_step = ADDR_W'(geom.kernel_row_step);
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            offset <= '0;
            kcol   <= '0;
            krow   <= '0;
        end else if (enable) begin
            if (evt.group_last) begin
                // new group starts at element 0
                offset <= '0;
                kcol   <= '0;
                krow   <= '0;
            end else if (evt.elem_last && !evt.tile_last) begin
                // next window, same block
                offset <= offset_save;
                kcol   <= kcol_save;
                krow   <= krow_save;
            end else begin
                // also carries on across a block end
                offset <= offset + offset_step;
                kcol   <= kcol_next;
                krow   <= krow_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (enable && evt.block_first) begin
            offset_save <= offset;
            kcol_save   <= kcol;
            krow_save   <= krow;
        end
    end

    assign kernel_offset = offset;

endmodule

// ==== source/tensor_addr_gen.sv ====
`timescale 1ns/1ps

module tensor_addr_gen (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          cfg_load,
    input  im2col_pkg::conv_cfg_t         cfg,
    input  logic                          enable,
    output logic [im2col_pkg::ADDR_W-1:0] o_tensor_addr,
    output logic                          padding_valid,
    output logic                          o_addr_valid,
    output logic                          o_tensor_done
);
    import im2col_pkg::*;

    geom_t             geom;
    tile_evt_t         evt;
    logic              elem_pad;
    logic              window_pad;
    logic              final_group;
    logic [ADDR_W-1:0] kernel_offset;
    logic [ADDR_W-1:0] window_base_addr;

    conv_geometry u_geometry (
        .clk      (clk),
        .rstn     (rstn),
        .cfg_load (cfg_load),
        .cfg      (cfg),
        .geom     (geom)
    );

    // group, block, window, element nest
    tile_counter u_tile (
        .clk      (clk),
        .rstn     (rstn),
        .enable   (enable),
        .geom     (geom),
        .evt      (evt),
        .elem_pad (elem_pad)
    );

    kernel_walker u_kernel (
        .clk           (clk),
        .rstn          (rstn),
        .enable        (enable),
        .geom          (geom),
        .evt           (evt),
        .kernel_offset (kernel_offset)
    );

    window_base u_window (
        .clk              (clk),
        .rstn             (rstn),
        .enable           (enable),
        .geom             (geom),
        .evt              (evt),
        .window_base_addr (window_base_addr),
        .window_pad       (window_pad),
        .final_group      (final_group)
    );

    addr_issue u_issue (
        .clk              (clk),
        .rstn             (rstn),
        .enable           (enable),
        .evt              (evt),
        .elem_pad         (elem_pad),
        .window_pad       (window_pad),
        .final_group      (final_group),
        .kernel_offset    (kernel_offset),
        .window_base_addr (window_base_addr),
        .o_tensor_addr    (o_tensor_addr),
        .padding_valid    (padding_valid),
        .o_addr_valid     (o_addr_valid),
        .o_tensor_done    (o_tensor_done)
    );

endmodule

// ==== source/tile_counter.sv ====
`timescale 1ns/1ps

module tile_counter (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  enable,
    input  im2col_pkg::geom_t     geom,
    output im2col_pkg::tile_evt_t evt,
    output logic                  elem_pad
);
    import im2col_pkg::*;

    // element within block, window within group, block within group
    logic [TILE_W-1:0]  elem_cnt;
    logic [TILE_W-1:0]  win_cnt;
    logic [BLOCK_W-1:0] block_cnt;

    // ************************************************************************
    // event qualifiers
    // ************************************************************************

    always_comb begin
        evt.elem_last   = (elem_cnt == TILE_LAST);
        evt.tile_last   = evt.elem_last && (win_cnt == TILE_LAST);
        evt.block_first = (elem_cnt == '0) && (win_cnt == '0);
        evt.group_first = evt.block_first && (block_cnt == '0);
        // last item of the last block ends the group
        evt.group_last  = evt.tile_last && (block_cnt == geom.block_last);
    end

    // columns past k*k*c in the final block
    assign elem_pad = (block_cnt == geom.block_last) && (elem_cnt > geom.tail_last);

    // ************************************************************************
    // counter nest
    // ************************************************************************

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            elem_cnt  <= '0;
            win_cnt   <= '0;
            block_cnt <= '0;
        end else if (enable) begin
            elem_cnt <= evt.elem_last ? '0 : elem_cnt + 1'b1;
            if (evt.elem_last) begin
                win_cnt <= evt.tile_last ? '0 : win_cnt + 1'b1;
            end
            // block wraps at group end, next group restarts at block 0
            if (evt.tile_last) begin
                block_cnt <= evt.group_last ? '0 : block_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== source/window_base.sv ====
`timescale 1ns/1ps

module window_base (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          enable,
    input  im2col_pkg::geom_t             geom,
    input  im2col_pkg::tile_evt_t         evt,
    output logic [im2col_pkg::ADDR_W-1:0] window_base_addr,
    output logic                          window_pad,
    output logic                          final_group
);
    import im2col_pkg::*;

    // output column, window index, window base and base of its row
    logic [TENSOR_W-1:0] ox;
    logic [ADDR_W-1:0]   win_idx;
    logic [ADDR_W-1:0]   base;
    logic [ADDR_W-1:0]   row_base;

    // first window of the group
    logic [TENSOR_W-1:0] ox_save;
    logic [ADDR_W-1:0]   base_save;
    logic [ADDR_W-1:0]   row_base_save;

    logic [TENSOR_W-1:0] ox_next;
    logic [ADDR_W-1:0]   base_next;
    logic [ADDR_W-1:0]   row_base_next;

    // ************************************************************************
    // window step, stride along the row, row_step at the row end
    // ************************************************************************

    always_comb begin
        ox_next       = ox + 1'b1;
        row_base_next = row_base;
        base_next     = base + ADDR_W'(geom.stride);
        if (ox == geom.out_last) begin
            ox_next       = '0;
            row_base_next = row_base + geom.row_step;
            base_next     = row_base_next;
        end
    end

    assign window_pad  = (win_idx > geom.win_last);
    // groups are aligned to TILE_SIZE windows
    assign final_group = (win_idx >> TILE_W) == (geom.win_last >> TILE_W);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ox       <= '0;
            win_idx  <= '0;
            base     <= '0;
            row_base <= '0;
        end else if (enable) begin
            if (evt.group_last && final_group) begin
                // walk complete, back to window 0
                ox       <= '0;
                win_idx  <= '0;
                base     <= '0;
                row_base <= '0;
            end else if (evt.tile_last && !evt.group_last) begin
                // next block revisits the group's windows
                ox       <= ox_save;
                win_idx  <= {win_idx[ADDR_W-1:TILE_W], TILE_W'(0)};
                base     <= base_save;
                row_base <= row_base_save;
            end else if (evt.elem_last) begin
                ox       <= ox_next;
                win_idx  <= win_idx + 1'b1;
                base     <= base_next;
                row_base <= row_base_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (enable && evt.group_first) begin
            ox_save       <= ox;
            base_save     <= base;
            row_base_save <= row_base;
        end
    end

    assign window_base_addr = base;

endmodule

// ==== include/addr_model.svh ====
`ifndef ADDR_MODEL_SVH
`define ADDR_MODEL_SVH

// expected item at a walk index, wraps at the walk length
function automatic im2col_pkg::issue_t expected_item(input im2col_pkg::conv_cfg_t cfg,
                                                     input int unsigned index);
    int unsigned t;
    int unsigned k;
    int unsigned s;
    int unsigned out_n;
    int unsigned n_win;
    int unsigned n_elem;
    int unsigned per_group;
    int unsigned total;
    int unsigned idx;
    int unsigned r;
    int unsigned w;
    int unsigned e;
    im2col_pkg::issue_t item;

    t = cfg.tensor_size;
    k = cfg.kernel_size;
    s = (cfg.stride == 0) ? 1 : cfg.stride;
    out_n  = (t - k) / s + 1;
    n_win  = out_n * out_n;
    n_elem = k * k * cfg.channels;
    // blocks of TILE_SIZE columns, TILE_SIZE windows each
    per_group = (n_elem + im2col_pkg::TILE_SIZE - 1) / im2col_pkg::TILE_SIZE
                * im2col_pkg::TILE_SIZE * im2col_pkg::TILE_SIZE;
    total = (n_win + im2col_pkg::TILE_SIZE - 1) / im2col_pkg::TILE_SIZE * per_group;
    idx   = index % total;
    r     = idx % per_group;

    // window from group and row in tile, element from block and column
    w = (idx / per_group) * im2col_pkg::TILE_SIZE
        + (r / im2col_pkg::TILE_SIZE) % im2col_pkg::TILE_SIZE;
    e = (r / (im2col_pkg::TILE_SIZE * im2col_pkg::TILE_SIZE)) * im2col_pkg::TILE_SIZE
        + r % im2col_pkg::TILE_SIZE;

    item.pad  = (e >= n_elem) || (w >= n_win);
    item.done = (idx == total - 1);
    item.addr = '0;
    if (!item.pad) begin
        item.addr = im2col_pkg::ADDR_W'((e / (k * k)) * t * t
                    + ((w / out_n) * s + (e % (k * k)) / k) * t
                    + (w % out_n) * s + e % k);
    end
    return item;
endfunction

`endif

// ==== tb/tensor_addr_gen_tb.sv ====
`timescale 1ns/1ps

module tensor_addr_gen_tb;
    import im2col_pkg::*;

    // item counts per walk, groups x blocks x TILE_SIZE^2
    localparam int BASIC_ITEMS  = 192;
    localparam int STRIDE_ITEMS = 240;
    localparam int PARTIAL      = 100;
    localparam int WALK_ITEMS   = 3 * BASIC_ITEMS + STRIDE_ITEMS + 2 * BASIC_ITEMS + PARTIAL;

    logic              clk;
    logic              rstn;
    logic              cfg_load;
    conv_cfg_t         cfg;
    logic              enable;
    logic [ADDR_W-1:0] o_tensor_addr;
    logic              padding_valid;
    logic              o_addr_valid;
    logic              o_tensor_done;

    int unsigned lcg_state;
    int          test_errs;
    int          error_count;
    int          tests_run;
    int          tests_failed;
    // items of the latest walk, in arrival order
    issue_t      seen [0:511];

    `include "addr_model.svh"

    tensor_addr_gen u_dut (
        .clk           (clk),
        .rstn          (rstn),
        .cfg_load      (cfg_load),
        .cfg           (cfg),
        .enable        (enable),
        .o_tensor_addr (o_tensor_addr),
        .padding_valid (padding_valid),
        .o_addr_valid  (o_addr_valid),
        .o_tensor_done (o_tensor_done)
    );

    always #4 clk = ~clk;

    // ************************************************************************
    // helpers
    // ************************************************************************

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    function automatic conv_cfg_t make_cfg(input int t, input int k, input int c, input int s);
        conv_cfg_t r;
        r.tensor_size = TENSOR_W'(t);
        r.kernel_size = KERNEL_W'(k);
        r.channels    = CHANNEL_W'(c);
        r.stride      = STRIDE_W'(s);
        return r;
    endfunction

    task automatic finish_test(input string name);
        tests_run++;
        error_count += test_errs;
        if (test_errs != 0) begin
            tests_failed++;
        end
        $display("test %s done, %0d errors", name, test_errs);
        test_errs = 0;
    endtask

    // geom settles one edge after cfg_load, enable held off two more
    task automatic load_config(input conv_cfg_t c);
        @(posedge clk);
        cfg      <= c;
        cfg_load <= 1'b1;
        @(posedge clk);
        cfg_load <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    // exactly n enabled edges, so the walk state ends where expected
    task automatic run_walk(input string name, input conv_cfg_t c, input int n, input bit stalls);
        int     issued;
        int     got;
        logic   en_val;
        logic   last_en;
        issue_t act;
        issue_t exp;

        issued  = 0;
        got     = 0;
        last_en = 1'b0;
        load_config(c);
        while (got < n) begin
            @(posedge clk);
            en_val = (issued < n) && (!stalls || (lcg_next() % 4 != 0));
            if (en_val) begin
                issued++;
            end
            enable <= en_val;
            // outputs reflect the enable seen at this edge
            @(negedge clk);
            if (o_addr_valid !== last_en) begin
                $display("FAILED %s o_addr_valid after item %0d expected %b actual %b",
                         name, got, last_en, o_addr_valid);
                test_errs++;
            end
            act.addr = o_tensor_addr;
            act.pad  = padding_valid;
            act.done = o_tensor_done;
            if (o_addr_valid === 1'b1) begin
                exp = expected_item(c, got);
                if (act !== exp) begin
                    $display("FAILED %s item %0d expected %h/%b/%b actual %h/%b/%b",
                             name, got, exp.addr, exp.pad, exp.done,
                             act.addr, act.pad, act.done);
                    test_errs++;
                end
                if (got < 512) begin
                    seen[got] = act;
                end
                got++;
            end else if (got > 0 && act !== seen[got - 1]) begin
                // outputs keep the last item while enable is low
                $display("FAILED %s hold after item %0d expected %h actual %h",
                         name, got - 1, seen[got - 1], act);
                test_errs++;
            end
            last_en = en_val;
        end
        @(posedge clk);
        enable <= 1'b0;
    endtask

    // ************************************************************************
    // directed tests
    // ************************************************************************

    task automatic basic_walk();
        int blk;
        run_walk("basic_walk", make_cfg(6, 3, 1, 1), BASIC_ITEMS, 1'b0);
        // 9 columns, so block 2 holds one real column
        for (int i = 0; i < BASIC_ITEMS; i++) begin
            blk = (i % 48) / (TILE_SIZE * TILE_SIZE);
            if (blk == 2 && (i % TILE_SIZE) > 0 && !seen[i].pad) begin
                $display("FAILED basic_walk item %0d expected pad 1 actual pad 0", i);
                test_errs++;
            end
        end
        finish_test("basic_walk");
    endtask

    task automatic stride_and_channels();
        run_walk("stride_and_channels", make_cfg(7, 3, 2, 2), STRIDE_ITEMS, 1'b0);
        finish_test("stride_and_channels");
    endtask

    // reuses the items of the stride walk, 80 items per group
    task automatic window_pad_and_done();
        int w;
        int done_cnt;
        done_cnt = 0;
        for (int i = 0; i < STRIDE_ITEMS; i++) begin
            w = (i / 80) * TILE_SIZE + ((i % 80) / TILE_SIZE) % TILE_SIZE;
            if (w > 8 && !seen[i].pad) begin
                $display("FAILED window_pad_and_done item %0d expected pad 1 actual pad 0", i);
                test_errs++;
            end
            if (seen[i].done) begin
                done_cnt++;
            end
        end
        if (done_cnt != 1 || !seen[STRIDE_ITEMS-1].done) begin
            $display("FAILED window_pad_and_done done count expected 1 actual %0d", done_cnt);
            test_errs++;
        end
        finish_test("window_pad_and_done");
    endtask

    task automatic stalled_walk();
        run_walk("stalled_walk", make_cfg(6, 3, 1, 1), BASIC_ITEMS, 1'b1);
        finish_test("stalled_walk");
    endtask

    task automatic restart_walk();
        run_walk("restart_walk", make_cfg(6, 3, 1, 1), 2 * BASIC_ITEMS, 1'b0);
        for (int i = 0; i < BASIC_ITEMS; i++) begin
            if (seen[i + BASIC_ITEMS] !== seen[i]) begin
                $display("FAILED restart_walk item %0d expected %h actual %h",
                         i + BASIC_ITEMS, seen[i], seen[i + BASIC_ITEMS]);
                test_errs++;
            end
        end
        finish_test("restart_walk");
    endtask

    task automatic reset_mid_walk();
        run_walk("reset_mid_walk", make_cfg(6, 3, 1, 1), PARTIAL, 1'b0);
        // reset lands while items are still being issued
        @(posedge clk);
        enable <= 1'b1;
        @(posedge clk);
        rstn <= 1'b0;
        @(negedge clk);
        if (o_addr_valid !== 1'b0 || padding_valid !== 1'b0 || o_tensor_done !== 1'b0
            || o_tensor_addr !== '0) begin
            $display("FAILED reset_mid_walk expected valid/pad/done/addr 0/0/0/0 actual %b/%b/%b/%h",
                     o_addr_valid, padding_valid, o_tensor_done, o_tensor_addr);
            test_errs++;
        end
        @(posedge clk);
        enable <= 1'b0;
        repeat (3) @(posedge clk);
        rstn <= 1'b1;
        // geom cleared too, so the walk needs a reload
        run_walk("reset_mid_walk", make_cfg(6, 3, 1, 1), BASIC_ITEMS, 1'b0);
        finish_test("reset_mid_walk");
    endtask

    // ************************************************************************
    // sequence and watchdog
    // ************************************************************************

    initial begin
        clk          = 1'b0;
        rstn         = 1'b0;
        cfg_load     = 1'b0;
        cfg          = '0;
        enable       = 1'b0;
        lcg_state    = 51337;
        test_errs    = 0;
        error_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (3) @(posedge clk);
        rstn <= 1'b1;

        basic_walk();
        stride_and_channels();
        window_pad_and_done();
        stalled_walk();
        restart_walk();
        reset_mid_walk();

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, error_count);
        if (tests_failed == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // four cycles per item at most, plus setup margin
    initial begin
        #(WALK_ITEMS * 4 * 8 + 2000);
        $display("watchdog timeout, the walks did not complete in time");
        $display("tests failed");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+include
source/im2col_pkg.sv
source/conv_geometry.sv
source/tile_counter.sv
source/kernel_walker.sv
source/window_base.sv
source/addr_issue.sv
source/tensor_addr_gen.sv
tb/tensor_addr_gen_tb.sv
